// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := tb_cache
FILELIST  := verilog.f
LOG       := sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== source/cache_core.sv ====
`default_nettype none

module cache_core #(
  parameter int XLEN  = cache_pkg::DEFAULT_XLEN,
  parameter int SETS  = cache_pkg::DEFAULT_SETS,
  parameter int WORDS = cache_pkg::DEFAULT_WORDS
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  cache_pkg::req_op_e          op,
  input  logic [XLEN-1:0]             op_addr,
  input  logic [XLEN-1:0]             op_wdata,
  output logic                        done,
  output logic [XLEN-1:0]             rdata,
  output logic                        push,
  output logic [XLEN-1:0]             push_addr,
  output logic [WORDS-1:0][XLEN-1:0]  push_line,
  input  logic                        full,
  output logic [XLEN-1:0]             lookup_addr,
  input  logic                        lookup_hit,
  output logic                        refill_req,
  output logic [XLEN-1:0]             refill_addr,
  input  logic                        refill_ready,
  input  logic [WORDS-1:0][XLEN-1:0]  refill_line
);
  import cache_pkg::*;

  localparam int WordBits = $clog2(WORDS);
  localparam int SetBits  = $clog2(SETS);
  localparam int OffBits  = WordBits + 2;
  localparam int TagBits  = XLEN - SetBits - OffBits;

  typedef enum logic [1:0] {
    S_IDLE,
    S_LOOKUP,
    S_EVICT,
    S_REFILL
  } core_state_e;

  core_state_e                fsm_q;
  logic [TagBits-1:0]         tag_q   [SETS];
  line_state_e                state_q [SETS];
  logic [WORDS-1:0][XLEN-1:0] line_q  [SETS];

  logic [WordBits-1:0]        word_idx;
  logic [SetBits-1:0]         set_idx;
  logic [TagBits-1:0]         tag_in;
  logic                       hit;
  logic [WORDS-1:0][XLEN-1:0] fill_line;

  assign word_idx = op_addr[OffBits-1:2];
  assign set_idx  = op_addr[OffBits+SetBits-1:OffBits];
  assign tag_in   = op_addr[XLEN-1:OffBits+SetBits];
  assign hit      = (state_q[set_idx] != INVALID) && (tag_q[set_idx] == tag_in);

  assign refill_addr = {tag_in, set_idx, {OffBits{1'b0}}};
  assign lookup_addr = refill_addr;
  assign refill_req  = (fsm_q == S_REFILL);

  // Refilled line with the write word merged in.
  always_comb begin
    fill_line = refill_line;
    if (op == OP_WRITE) begin
      fill_line[word_idx] = op_wdata;
    end
  end

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      fsm_q <= S_IDLE;
      done  <= 1'b0;
      push  <= 1'b0;
      for (int i = 0; i < SETS; i++) begin
        state_q[i] <= INVALID;
      end
    end else begin
      done <= 1'b0;
      push <= 1'b0;
      case (fsm_q)
        S_IDLE: begin
          // The finished request is still on op while done is high.
          if (op != OP_NONE && !done) begin
            fsm_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          if (hit) begin
            if (op == OP_WRITE) begin
              line_q[set_idx][word_idx] <= op_wdata;
              state_q[set_idx]          <= MODIFIED;
            end
            rdata <= line_q[set_idx][word_idx];
            done  <= 1'b1;
            fsm_q <= S_IDLE;
          end else if (state_q[set_idx] == MODIFIED) begin
            fsm_q <= S_EVICT;
          end else begin
            fsm_q <= S_REFILL;
          end
        end
        S_EVICT: begin
          if (!full) begin
            push      <= 1'b1;
            push_addr <= {tag_q[set_idx], set_idx, {OffBits{1'b0}}};
            push_line <= line_q[set_idx];
            fsm_q     <= S_REFILL;
          end
        end
        S_REFILL: begin
          if (refill_ready) begin
            tag_q[set_idx]   <= tag_in;
            line_q[set_idx]  <= fill_line;
            state_q[set_idx] <= (op == OP_WRITE) ? MODIFIED : VALID;
            rdata            <= refill_line[word_idx];
            done             <= 1'b1;
            fsm_q            <= S_IDLE;
          end
        end
        default: fsm_q <= S_IDLE;
      endcase
    end
  end

  a_push_not_full: assert property (@(posedge gsi) disable iff (!rst_n)
    push |-> !full);

  a_refill_held: assert property (@(posedge gsi) disable iff (!rst_n)
    refill_req && !refill_ready |=> refill_req && $stable(refill_addr));

  // Memory must be current before the refill data comes back.
  a_refill_after_drain: assert property (@(posedge gsi) disable iff (!rst_n)
    refill_ready |-> !lookup_hit);

endmodule

`default_nettype wire

// ==== source/cache_pkg.sv ====
`default_nettype none

package cache_pkg;

  // State of one cache line.
  typedef enum logic [1:0] {
    INVALID,
    VALID,
    MODIFIED
  } line_state_e;

  // Operation handed from the arbiter to the core.
  typedef enum logic [1:0] {
    OP_NONE,
    OP_READ,
    OP_WRITE
  } req_op_e;

  // Default geometry.
  localparam int DEFAULT_XLEN = 32;
  localparam int DEFAULT_SETS = 8;
  localparam int DEFAULT_WORDS = 4;
  localparam int DEFAULT_WB_DEPTH = 4;

endpackage

`default_nettype wire

// ==== source/cache_top.sv ====
`default_nettype none

module cache_top #(
  parameter int XLEN     = cache_pkg::DEFAULT_XLEN,
  parameter int SETS     = cache_pkg::DEFAULT_SETS,
  parameter int WORDS    = cache_pkg::DEFAULT_WORDS,
  parameter int WB_DEPTH = cache_pkg::DEFAULT_WB_DEPTH
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  logic                        p0_read,
  input  logic                        p0_write,
  input  logic [XLEN-1:0]             p0_addr,
  input  logic [XLEN-1:0]             p0_wdata,
  output logic [XLEN-1:0]             p0_rdata,
  output logic                        p0_ack,
  input  logic                        p1_read,
  input  logic                        p1_write,
  input  logic [XLEN-1:0]             p1_addr,
  input  logic [XLEN-1:0]             p1_wdata,
  output logic [XLEN-1:0]             p1_rdata,
  output logic                        p1_ack,
  output logic                        mem_read,
  output logic                        mem_write,
  output logic [XLEN-1:0]             mem_addr,
  output logic [WORDS-1:0][XLEN-1:0]  mem_wdata,
  input  logic [WORDS-1:0][XLEN-1:0]  mem_rdata,
  input  logic                        mem_ready,
  input  logic                        mem_done
);
  import cache_pkg::*;

  req_op_e                    op;
  logic                       op_port;
  logic [XLEN-1:0]            op_addr;
  logic [XLEN-1:0]            op_wdata;
  logic                       done;
  logic [XLEN-1:0]            rdata;
  logic                       push;
  logic [XLEN-1:0]            push_addr;
  logic [WORDS-1:0][XLEN-1:0] push_line;
  logic                       full;
  logic                       empty;
  logic [XLEN-1:0]            head_addr;
  logic [WORDS-1:0][XLEN-1:0] head_line;
  logic                       pop;
  logic [XLEN-1:0]            lookup_addr;
  logic                       lookup_hit;
  logic                       refill_req;
  logic [XLEN-1:0]            refill_addr;
  logic                       refill_ready;
  logic [WORDS-1:0][XLEN-1:0] refill_line;

  request_arbiter #(.XLEN(XLEN)) request_arbiter_i (.*);

  cache_core #(.XLEN(XLEN), .SETS(SETS), .WORDS(WORDS)) cache_core_i (.*);

  write_buffer #(.XLEN(XLEN), .WORDS(WORDS), .WB_DEPTH(WB_DEPTH)) write_buffer_i (.*);

  memory_port #(.XLEN(XLEN), .WORDS(WORDS)) memory_port_i (.*);

endmodule

`default_nettype wire

// ==== source/memory_port.sv ====
`default_nettype none

module memory_port #(
  parameter int XLEN  = cache_pkg::DEFAULT_XLEN,
  parameter int WORDS = cache_pkg::DEFAULT_WORDS
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  logic                        refill_req,
  input  logic [XLEN-1:0]             refill_addr,
  output logic                        refill_ready,
  output logic [WORDS-1:0][XLEN-1:0]  refill_line,
  input  logic                        lookup_hit,
  input  logic                        empty,
  input  logic [XLEN-1:0]             head_addr,
  input  logic [WORDS-1:0][XLEN-1:0]  head_line,
  output logic                        pop,
  output logic                        mem_read,
  output logic                        mem_write,
  output logic [XLEN-1:0]             mem_addr,
  output logic [WORDS-1:0][XLEN-1:0]  mem_wdata,
  input  logic [WORDS-1:0][XLEN-1:0]  mem_rdata,
  input  logic                        mem_ready,
  input  logic                        mem_done
);
  typedef enum logic [1:0] {
    P_IDLE,
    P_READ,
    P_WRITE
  } port_state_e;

  port_state_e state_q;

  assign refill_ready = (state_q == P_READ) && mem_ready;
  assign refill_line  = mem_rdata;
  assign pop          = (state_q == P_WRITE) && mem_done;

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      state_q   <= P_IDLE;
      mem_read  <= 1'b0;
      mem_write <= 1'b0;
    end else begin
      case (state_q)
        P_IDLE: begin
          // Refill first, unless its line still waits in the buffer.
          if (refill_req && !lookup_hit) begin
            mem_read <= 1'b1;
            mem_addr <= refill_addr;
            state_q  <= P_READ;
          end else if (!empty) begin
            mem_write <= 1'b1;
            mem_addr  <= head_addr;
            mem_wdata <= head_line;
            state_q   <= P_WRITE;
          end
        end
        P_READ: begin
          if (mem_ready) begin
            mem_read <= 1'b0;
            state_q  <= P_IDLE;
          end
        end
        P_WRITE: begin
          if (mem_done) begin
            mem_write <= 1'b0;
            state_q   <= P_IDLE;
          end
        end
        default: state_q <= P_IDLE;
      endcase
    end
  end

  a_bus_exclusive: assert property (@(posedge gsi) disable iff (!rst_n)
    !(mem_read && mem_write));

endmodule

`default_nettype wire

// ==== source/request_arbiter.sv ====
`default_nettype none

module request_arbiter #(
  parameter int XLEN = cache_pkg::DEFAULT_XLEN
) (
  input  logic                gsi,
  input  logic                rst_n,
  input  logic                p0_read,
  input  logic                p0_write,
  input  logic [XLEN-1:0]     p0_addr,
  input  logic [XLEN-1:0]     p0_wdata,
  input  logic                p1_read,
  input  logic                p1_write,
  input  logic [XLEN-1:0]     p1_addr,
  input  logic [XLEN-1:0]     p1_wdata,
  output logic [XLEN-1:0]     p0_rdata,
  output logic                p0_ack,
  output logic [XLEN-1:0]     p1_rdata,
  output logic                p1_ack,
  output cache_pkg::req_op_e  op,
  output logic                op_port,
  output logic [XLEN-1:0]     op_addr,
  output logic [XLEN-1:0]     op_wdata,
  input  logic                done,
  input  logic [XLEN-1:0]     rdata
);
  import cache_pkg::*;

  logic p0_req;
  logic p1_req;
  logic pick;

  assign p0_req = p0_read || p0_write;
  assign p1_req = p1_read || p1_write;

  // op_port doubles as the last-served bit, a tie goes to the other port.
  assign pick = p1_req && (!p0_req || !op_port);

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      op      <= OP_NONE;
      op_port <= 1'b0;
    end else if (op == OP_NONE) begin
      if (p0_req || p1_req) begin
        op_port <= pick;
        if (pick) begin
          op       <= p1_write ? OP_WRITE : OP_READ;
          op_addr  <= p1_addr;
          op_wdata <= p1_wdata;
        end else begin
          op       <= p0_write ? OP_WRITE : OP_READ;
          op_addr  <= p0_addr;
          op_wdata <= p0_wdata;
        end
      end
    end else if (done) begin
      // One idle cycle lets the requester drop its strobe.
      op <= OP_NONE;
    end
  end

  assign p0_ack   = done && !op_port;
  assign p1_ack   = done && op_port;
  assign p0_rdata = rdata;
  assign p1_rdata = rdata;

  a_strobe_exclusive: assert property (@(posedge gsi) disable iff (!rst_n)
    !(p0_read && p0_write) && !(p1_read && p1_write));

endmodule

`default_nettype wire

// ==== source/write_buffer.sv ====
`default_nettype none

module write_buffer #(
  parameter int XLEN     = cache_pkg::DEFAULT_XLEN,
  parameter int WORDS    = cache_pkg::DEFAULT_WORDS,
  parameter int WB_DEPTH = cache_pkg::DEFAULT_WB_DEPTH
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  logic                        push,
  input  logic [XLEN-1:0]             push_addr,
  input  logic [WORDS-1:0][XLEN-1:0]  push_line,
  output logic                        full,
  output logic                        empty,
  output logic [XLEN-1:0]             head_addr,
  output logic [WORDS-1:0][XLEN-1:0]  head_line,
  input  logic                        pop,
  input  logic [XLEN-1:0]             lookup_addr,
  output logic                        lookup_hit
);
  localparam int PtrBits = $clog2(WB_DEPTH);

  logic [XLEN-1:0]            addr_q [WB_DEPTH];
  logic [WORDS-1:0][XLEN-1:0] line_q [WB_DEPTH];
  logic [WB_DEPTH-1:0]        valid_q;
  logic [PtrBits-1:0]         wr_ptr;
  logic [PtrBits-1:0]         rd_ptr;
  logic [WB_DEPTH-1:0]        match;

  function automatic logic [PtrBits-1:0] next_ptr(input logic [PtrBits-1:0] ptr);
    return (ptr == PtrBits'(WB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full      = &valid_q;
  assign empty     = ~|valid_q;
  assign head_addr = addr_q[rd_ptr];
  assign head_line = line_q[rd_ptr];

  always_comb begin
    for (int i = 0; i < WB_DEPTH; i++) begin
      match[i] = valid_q[i] && (addr_q[i] == lookup_addr);
    end
  end

  assign lookup_hit = |match;

  always_ff @(posedge gsi) begin
    if (!rst_n) begin
      valid_q <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end else begin
      // Push and pop never hit the same slot.
      if (push) begin
        valid_q[wr_ptr] <= 1'b1;
        wr_ptr          <= next_ptr(wr_ptr);
      end
      if (pop) begin
        valid_q[rd_ptr] <= 1'b0;
        rd_ptr          <= next_ptr(rd_ptr);
      end
    end
  end

  always_ff @(posedge gsi) begin
    if (push) begin
      addr_q[wr_ptr] <= push_addr;
      line_q[wr_ptr] <= push_line;
    end
  end

  a_no_pop_empty: assert property (@(posedge gsi) disable iff (!rst_n) pop |-> !empty);
  a_no_push_full: assert property (@(posedge gsi) disable iff (!rst_n) push |-> !full);

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`default_nettype none

module mem_model #(
  parameter int XLEN  = cache_pkg::DEFAULT_XLEN,
  parameter int WORDS = cache_pkg::DEFAULT_WORDS,
  parameter int LINES = 64
) (
  input  logic                        gsi,
  input  logic                        rst_n,
  input  logic                        mem_read,
  input  logic                        mem_write,
  input  logic [XLEN-1:0]             mem_addr,
  input  logic [WORDS-1:0][XLEN-1:0]  mem_wdata,
  output logic [WORDS-1:0][XLEN-1:0]  mem_rdata,
  output logic                        mem_ready,
  output logic                        mem_done
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int off_bits  = $clog2(WORDS) + 2;
  localparam int line_bits = $clog2(LINES);

  logic [WORDS-1:0][XLEN-1:0] mem [LINES];
  logic [line_bits-1:0]       line_idx;
  logic                       busy;
  logic [2:0]                 wait_q;

  assign line_idx = mem_addr[off_bits +: line_bits];

  // Each word starts as a function of its byte address.
  initial begin
    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < WORDS; w++) begin
        mem[l][w] = 32'hbeef_0000 ^ (XLEN'((l * WORDS + w) * 4) * 32'd2654435761);
      end
    end
  end

  always @(posedge gsi) begin
    mem_ready <= 1'b0;
    mem_done  <= 1'b0;
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (mem_ready || mem_done) begin
      // The port drops its strobe on this edge.
      busy <= 1'b0;
    end else if (!busy) begin
      if (mem_read || mem_write) begin
        busy   <= 1'b1;
        wait_q <= 3'($urandom_range(0, 5));
      end
    end else if (wait_q != 3'd0) begin
      wait_q <= wait_q - 1'b1;
    end else if (mem_read) begin
      mem_rdata <= mem[line_idx];
      mem_ready <= 1'b1;
    end else begin
      mem[line_idx] <= mem_wdata;
      mem_done      <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== tb/tb_cache.sv ====
`default_nettype none

module tb_cache;
  timeunit 1ns;
  timeprecision 100ps;

  import cache_pkg::*;

  localparam int xlen = DEFAULT_XLEN;
  localparam int words = DEFAULT_WORDS;
  localparam int random_ops = 150;
  localparam int burst_ops = 24;
  localparam int max_cycles = 400 * 40;

  logic gsi = 1'b0;
  logic rst_n;
  logic p0_read, p0_write, p0_ack, p1_read, p1_write, p1_ack;
  logic [xlen-1:0] p0_addr, p0_wdata, p0_rdata, p1_addr, p1_wdata, p1_rdata;
  logic mem_read, mem_write, mem_ready, mem_done;
  logic [xlen-1:0] mem_addr;
  logic [words-1:0][xlen-1:0] mem_wdata, mem_rdata;

  // Expected word for each address of the 128-word window.
  logic [xlen-1:0] shadow [128];
  logic [xlen-1:0] p0_expect, p1_expect;
  logic [xlen-1:0] p0_written [$];
  logic [xlen-1:0] p1_written [$];
  logic started;
  int errors;
  int cycles;

  cache_top #(.XLEN(xlen), .WORDS(words)) cache_top_i (.*);
  mem_model #(.XLEN(xlen), .WORDS(words), .LINES(64)) mem_model_i (.*);

  initial begin
    forever #2 gsi = ~gsi;
  end

  // Memory content before any write, taken from the full byte address.
  function automatic logic [xlen-1:0] initial_word(input logic [xlen-1:0] addr);
    return 32'hbeef_0000 ^ (addr * 32'd2654435761);
  endfunction

  function automatic logic [xlen-1:0] random_addr();
    return xlen'($urandom_range(0, 127) * 4);
  endfunction

  // Tags 0 to 3 of set 5, any word.
  function automatic logic [xlen-1:0] conflict_addr(input int tag);
    return xlen'((tag * 32 + 20 + $urandom_range(0, 3)) * 4);
  endfunction

  task automatic port0_access(input logic wr, input logic [xlen-1:0] addr,
                              input logic [xlen-1:0] data);
    p0_read  = !wr;
    p0_write = wr;
    p0_addr  = addr;
    p0_wdata = data;
    do begin
      @(negedge gsi);
    end while (!p0_ack);
    // Request stays up over the edge where the ack is sampled.
    @(negedge gsi);
    p0_read  = 1'b0;
    p0_write = 1'b0;
  endtask

  task automatic port1_access(input logic wr, input logic [xlen-1:0] addr,
                              input logic [xlen-1:0] data);
    p1_read  = !wr;
    p1_write = wr;
    p1_addr  = addr;
    p1_wdata = data;
    do begin
      @(negedge gsi);
    end while (!p1_ack);
    @(negedge gsi);
    p1_read  = 1'b0;
    p1_write = 1'b0;
  endtask

  task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] expected);
    errors++;
    $display("Fail %0t %s got %h expected %h", $time, name, got, expected);
  endtask

  task automatic report_violation(input string what);
    errors++;
    $display("Protocol error at %0t: %s", $time, what);
  endtask

  task automatic finish_run();
    $display("Checks failed: %0d, cycles run: %0d", errors, cycles);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  endtask

  assign p0_expect = shadow[p0_addr[8:2]];
  assign p1_expect = shadow[p1_addr[8:2]];

  always @(posedge gsi) begin
    if (p0_ack && p0_write) begin
      shadow[p0_addr[8:2]] <= p0_wdata;
    end
    if (p1_ack && p1_write) begin
      shadow[p1_addr[8:2]] <= p1_wdata;
    end
  end

  always @(posedge gsi) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (p0_read || p0_write || p1_read || p1_write) begin
      started <= 1'b1;
    end
  end

  always @(posedge gsi) begin
    cycles <= cycles + 1;
    if (cycles == max_cycles) begin
      $display("Timeout after %0d cycles, a request is still waiting for its ack", cycles);
      errors++;
      finish_run();
    end
  end

  a_quiet_before_use: assert property (@(posedge gsi) disable iff (!rst_n)
    !started |-> {p0_ack, p1_ack, mem_read, mem_write} == 4'b0000)
    else report_mismatch("{p0_ack,p1_ack,mem_read,mem_write}",
                         xlen'($sampled({p0_ack, p1_ack, mem_read, mem_write})), '0);
  a_p0_rdata: assert property (@(posedge gsi) disable iff (!rst_n)
    p0_ack && p0_read |-> p0_rdata == p0_expect)
    else report_mismatch("p0_rdata", $sampled(p0_rdata), $sampled(p0_expect));
  a_p1_rdata: assert property (@(posedge gsi) disable iff (!rst_n)
    p1_ack && p1_read |-> p1_rdata == p1_expect)
    else report_mismatch("p1_rdata", $sampled(p1_rdata), $sampled(p1_expect));
  a_ack_owned: assert property (@(posedge gsi) disable iff (!rst_n)
    !(p0_ack && !p0_read && !p0_write) && !(p1_ack && !p1_read && !p1_write))
    else report_violation("an ack came on a port with no pending request");
  a_ack_single: assert property (@(posedge gsi) disable iff (!rst_n)
    p0_ack || p1_ack |=> !p0_ack && !p1_ack)
    else report_violation("one request was acknowledged twice");
  a_bus_exclusive: assert property (@(posedge gsi) disable iff (!rst_n)
    !(mem_read && mem_write))
    else report_violation("mem_read and mem_write were high together");
  a_read_held: assert property (@(posedge gsi) disable iff (!rst_n)
    mem_read && !mem_ready |=> mem_read && $stable(mem_addr))
    else report_violation("mem_read or mem_addr changed before mem_ready");
  a_write_held: assert property (@(posedge gsi) disable iff (!rst_n)
    mem_write && !mem_done |=> mem_write && $stable(mem_addr) && $stable(mem_wdata))
    else report_violation("mem_write, mem_addr or mem_wdata changed before mem_done");

  initial begin
    int idle;
    void'($urandom(32'hffe8));
    {p0_read, p0_write, p1_read, p1_write} = 4'b0000;
    p0_addr  = '0;
    p0_wdata = '0;
    p1_addr  = '0;
    p1_wdata = '0;
    errors   = 0;
    cycles   = 0;
    rst_n    = 1'b0;
    for (int i = 0; i < 128; i++) begin
      shadow[i] = initial_word(xlen'(i * 4));
    end
    repeat (16) @(negedge gsi);
    rst_n = 1'b1;
    repeat (4) @(negedge gsi);

    // Mixed traffic from both ports over four tags of every set.
    fork
      for (int i = 0; i < random_ops; i++) begin
        port0_access(1'($urandom_range(0, 1)), random_addr(), $urandom());
      end
      for (int i = 0; i < random_ops; i++) begin
        port1_access(1'($urandom_range(0, 1)), random_addr(), $urandom());
      end
    join

    // Write burst into one set, every access evicts a dirty line.
    fork
      for (int i = 0; i < burst_ops; i++) begin
        p0_written.push_back(conflict_addr(i % 4));
        port0_access(1'b1, p0_written[i], $urandom());
      end
      for (int i = 0; i < burst_ops; i++) begin
        p1_written.push_back(conflict_addr((i + 2) % 4));
        port1_access(1'b1, p1_written[i], $urandom());
      end
    join

    idle = 0;
    while (idle < 8) begin
      @(negedge gsi);
      idle = (mem_read || mem_write) ? 0 : idle + 1;
    end

    // Each port reads back what the other one wrote.
    fork
      foreach (p1_written[i]) port0_access(1'b0, p1_written[i], '0);
      foreach (p0_written[i]) port1_access(1'b0, p0_written[i], '0);
    join
    repeat (4) @(negedge gsi);
    finish_run();
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/cache_pkg.sv
source/request_arbiter.sv
source/cache_core.sv
source/write_buffer.sv
source/memory_port.sv
source/cache_top.sv
tb/mem_model.sv
tb/tb_cache.sv
